// File: tank_pkg.sv
/* tank game shared definitions
   grid coordinates, headings, counters and fixed game constants */

`default_nettype none

package tank_pkg;

	// 32 x 32 cell playfield
	localparam int COORD_W = 5;

	typedef logic [COORD_W-1:0] coord_t;

	localparam coord_t COORD_MAX = coord_t'(31);	// last row / column

	// heading, same order as the button set w, a, s, d
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_LEFT  = 2'd1,
		DIR_DOWN  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	localparam int N_ENEMY = 4;

	// score saturates at 63
	typedef logic [5:0] score_t;

	typedef logic [2:0] hp_t;

	localparam hp_t HP_INIT = hp_t'(3);

	// player start cell, near the bottom edge
	localparam coord_t PLAYER_X0 = coord_t'(16);
	localparam coord_t PLAYER_Y0 = coord_t'(30);

	// one fixed column per enemy
	localparam coord_t SPAWN_X [N_ENEMY] = '{
		coord_t'(4),
		coord_t'(12),
		coord_t'(20),
		coord_t'(28)
	};

endpackage

`default_nettype wire

// File: game_if.sv
/* tank and bullet state buses
   src side owns the state, dst side observes it */

`timescale 1ns/1ps
`default_nettype none

interface tank_if import tank_pkg::*; ();

	coord_t x;
	coord_t y;
	dir_t   dir;
	logic   fire;	// one-cycle shoot strobe

	modport src (
		output x, y, dir, fire
	);

	modport dst (
		input x, y, dir, fire
	);

endinterface

interface bullet_if import tank_pkg::*; ();

	logic   active;
	coord_t x;
	coord_t y;
	dir_t   dir;	// flight direction, fixed at launch

	modport src (
		output active, x, y, dir
	);

	modport dst (
		input active, x, y, dir
	);

endinterface

`default_nettype wire

// File: game_tick.sv
/* game pacing, move tick every TICK_DIV cycles and bullet tick twice as often */

`timescale 1ns/1ps
`default_nettype none

module game_tick #(
	parameter int TICK_DIV = 16
) (
	input  logic clk,
	input  logic arst_n,
	input  logic gameover,
	output logic move_tick,
	output logic bullet_tick
);

	localparam int CNT_W = $clog2(TICK_DIV);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(TICK_DIV - 1);
	localparam logic [CNT_W-1:0] HALF = CNT_W'(TICK_DIV / 2 - 1);

	logic [CNT_W-1:0] cnt;

	// counter freezes once the game is over
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (!gameover) begin
			cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
		end
	end

	assign move_tick   = !gameover && (cnt == LAST);
	assign bullet_tick = !gameover && ((cnt == LAST) || (cnt == HALF));	// mid and end of period

endmodule

`default_nettype wire

// File: player_tank.sv
/* player tank, moves one cell per tick under button control
   and turns a shoot press into a fire strobe while the bullet is idle */

`timescale 1ns/1ps
`default_nettype none

module player_tank import tank_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic bt_w,
	input  logic bt_a,
	input  logic bt_s,
	input  logic bt_d,
	input  logic bt_st,
	input  logic move_tick,
	bullet_if.dst bul,
	tank_if.src tank
);

	logic st_meta;
	logic st_sync;
	logic st_prev;
	logic st_rise;

	// shoot button sync and edge detect
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st_meta <= 1'b0;
			st_sync <= 1'b0;
			st_prev <= 1'b0;
		end else begin
			st_meta <= bt_st;
			st_sync <= st_meta;
			st_prev <= st_sync;
		end
	end

	assign st_rise = st_sync && !st_prev;

	// one bullet at a time, presses during flight are dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tank.fire <= 1'b0;
		end else begin
			tank.fire <= st_rise && !bul.active;
		end
	end

	// w beats a beats s beats d
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tank.x   <= PLAYER_X0;
			tank.y   <= PLAYER_Y0;
			tank.dir <= DIR_UP;
		end else if (move_tick) begin
			if (bt_w) begin
				tank.dir <= DIR_UP;
				if (tank.y != '0)
					tank.y <= tank.y - 1'b1;
			end else if (bt_a) begin
				tank.dir <= DIR_LEFT;
				if (tank.x != '0)
					tank.x <= tank.x - 1'b1;
			end else if (bt_s) begin
				tank.dir <= DIR_DOWN;
				if (tank.y != COORD_MAX)
					tank.y <= tank.y + 1'b1;
			end else if (bt_d) begin
				tank.dir <= DIR_RIGHT;
				if (tank.x != COORD_MAX)
					tank.x <= tank.x + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: bullet.sv
/* player bullet, launched from the tank on fire and flown one cell
   per bullet tick until it hits an enemy or reaches the grid edge */

`timescale 1ns/1ps
`default_nettype none

module bullet import tank_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               bullet_tick,
	tank_if.dst                tank,
	input  logic [N_ENEMY-1:0] kill,
	bullet_if.src              bul
);

	logic at_edge;	// next step would leave the grid
	logic step;

	always_comb begin
		case (bul.dir)
			DIR_UP:    at_edge = (bul.y == '0);
			DIR_LEFT:  at_edge = (bul.x == '0);
			DIR_DOWN:  at_edge = (bul.y == COORD_MAX);
			default:   at_edge = (bul.x == COORD_MAX);
		endcase
	end

	assign step = bul.active && bullet_tick;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bul.active <= 1'b0;
		end else if (|kill) begin
			bul.active <= 1'b0;	// any enemy hit retires it
		end else if (tank.fire) begin
			bul.active <= 1'b1;
		end else if (step && at_edge) begin
			bul.active <= 1'b0;
		end
	end

	// position and heading
	always_ff @(posedge clk) begin
		if (tank.fire) begin
			bul.x   <= tank.x;
			bul.y   <= tank.y;
			bul.dir <= tank.dir;
		end else if (step && !at_edge) begin
			case (bul.dir)
				DIR_UP:    bul.y <= bul.y - 1'b1;
				DIR_LEFT:  bul.x <= bul.x - 1'b1;
				DIR_DOWN:  bul.y <= bul.y + 1'b1;
				default:   bul.x <= bul.x + 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: enemy_tank.sv
/* one enemy tank marching down a fixed column
   flags bullet hits and player collisions, then respawns at the top */

`timescale 1ns/1ps
`default_nettype none

module enemy_tank import tank_pkg::*; #(
	parameter coord_t SPAWN_COL = '0
) (
	input  logic clk,
	input  logic arst_n,
	input  logic move_tick,
	tank_if.dst  player,
	bullet_if.dst bul,
	output logic kill,
	output logic bump
);

	coord_t y;	// current row
	logic   hit;
	logic   crash;

	// at most one cell apart, no wrap between 0 and 31
	function automatic logic near(input coord_t a, input coord_t b);
		coord_t d;
		d = (a > b) ? a - b : b - a;
		return d <= coord_t'(1);
	endfunction

	// same column with close rows, or same row with close columns
	always_comb begin
		hit = 1'b0;
		if (bul.active) begin
			if (bul.x == SPAWN_COL && near(bul.y, y))
				hit = 1'b1;
			if (bul.y == y && near(bul.x, SPAWN_COL))
				hit = 1'b1;
		end
	end

	assign crash = (player.x == SPAWN_COL) && (player.y == y);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			y    <= '0;
			kill <= 1'b0;
			bump <= 1'b0;
		end else begin
			kill <= hit && !kill;	// stale bullet is still shown for a cycle
			bump <= crash;
			if ((hit && !kill) || crash) begin
				y <= '0;
			end else if (move_tick) begin
				y <= y + 1'b1;	// wraps 31 -> 0
			end
		end
	end

endmodule

`default_nettype wire

// File: game_state.sv
/* classic mode bookkeeping
   saturating score, hit points and latched game over */

`timescale 1ns/1ps
`default_nettype none

module game_state import tank_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [N_ENEMY-1:0] kill,
	input  logic [N_ENEMY-1:0] bump,
	output score_t             score,
	output hp_t                hp,
	output logic               gameover
);

	localparam int SCORE_W = $bits(score_t);
	localparam int NK_W    = $clog2(N_ENEMY + 1);

	logic [NK_W-1:0]    n_kill;
	logic [SCORE_W:0]   score_sum;	// one spare bit for overflow
	score_t             score_next;
	hp_t                hp_next;

	always_comb begin
		n_kill = '0;
		for (int i = 0; i < N_ENEMY; i++)
			n_kill = n_kill + NK_W'(kill[i]);
	end

	assign score_sum  = {1'b0, score} + (SCORE_W + 1)'(n_kill);
	assign score_next = score_sum[SCORE_W] ? '1 : score_sum[SCORE_W-1:0];

	// several bumps in one cycle cost a single point
	assign hp_next = (|bump && hp != '0) ? hp - 1'b1 : hp;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			score    <= '0;
			hp       <= HP_INIT;
			gameover <= 1'b0;
		end else if (!gameover) begin
			score    <= score_next;
			hp       <= hp_next;
			gameover <= (hp_next == '0);
		end
	end

endmodule

`default_nettype wire

// File: tank_game_top.sv
/* tank game core, ticks, player, bullet, four enemies and scoring */

`timescale 1ns/1ps
`default_nettype none

module tank_game_top import tank_pkg::*; #(
	parameter int TICK_DIV = 16
) (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   bt_w,
	input  logic   bt_a,
	input  logic   bt_s,
	input  logic   bt_d,
	input  logic   bt_st,
	output coord_t player_x,
	output coord_t player_y,
	output dir_t   player_dir,
	output logic   bullet_active,
	output coord_t bullet_x,
	output coord_t bullet_y,
	output score_t score,
	output hp_t    hp,
	output logic   gameover
);

	logic               move_tick;
	logic               bullet_tick;
	logic [N_ENEMY-1:0] kill;
	logic [N_ENEMY-1:0] bump;

	tank_if   tank ();
	bullet_if bul ();

	game_tick #(
		.TICK_DIV    (TICK_DIV)
	) u_game_tick (
		.clk         (clk),
		.arst_n      (arst_n),
		.gameover    (gameover),
		.move_tick   (move_tick),
		.bullet_tick (bullet_tick)
	);

	player_tank u_player_tank (
		.clk       (clk),
		.arst_n    (arst_n),
		.bt_w      (bt_w),
		.bt_a      (bt_a),
		.bt_s      (bt_s),
		.bt_d      (bt_d),
		.bt_st     (bt_st),
		.move_tick (move_tick),
		.bul       (bul.dst),
		.tank      (tank.src)
	);

	bullet u_bullet (
		.clk         (clk),
		.arst_n      (arst_n),
		.bullet_tick (bullet_tick),
		.tank        (tank.dst),
		.kill        (kill),
		.bul         (bul.src)
	);

	// one enemy per spawn column
	for (genvar i = 0; i < N_ENEMY; i++) begin : g_enemy
		enemy_tank #(
			.SPAWN_COL (SPAWN_X[i])
		) u_enemy_tank (
			.clk       (clk),
			.arst_n    (arst_n),
			.move_tick (move_tick),
			.player    (tank.dst),
			.bul       (bul.dst),
			.kill      (kill[i]),
			.bump      (bump[i])
		);
	end

	game_state u_game_state (
		.clk      (clk),
		.arst_n   (arst_n),
		.kill     (kill),
		.bump     (bump),
		.score    (score),
		.hp       (hp),
		.gameover (gameover)
	);

	assign player_x      = tank.x;
	assign player_y      = tank.y;
	assign player_dir    = tank.dir;
	assign bullet_active = bul.active;
	assign bullet_x      = bul.x;
	assign bullet_y      = bul.y;

endmodule

`default_nettype wire

// File: tank_game_checker.sv
/* tank game checker, concurrent assertions on the top level outputs */

`timescale 1ns/1ps
`default_nettype none

module tank_game_checker import tank_pkg::*; (
	input logic   clk,
	input logic   arst_n,
	input coord_t player_x,
	input coord_t player_y,
	input logic   bullet_active,
	input coord_t bullet_x,
	input coord_t bullet_y,
	input hp_t    hp,
	input logic   gameover
);

	// a wrap from one edge to the other shows as a jump of 31 cells
	function automatic logic one_step(input coord_t a, input coord_t b);
		int d;
		d = int'(a) - int'(b);
		return (d >= -1) && (d <= 1);
	endfunction

	a_bullet_on_grid: assert property (@(posedge clk) disable iff (!arst_n)
		bullet_active && $past(bullet_active) |-> !$isunknown({bullet_x, bullet_y})
			&& one_step(bullet_x, $past(bullet_x)) && one_step(bullet_y, $past(bullet_y)))
		else $error("bullet outside the grid");

	a_hp_no_rise: assert property (@(posedge clk) disable iff (!arst_n)
		hp <= $past(hp))
		else $error("hp rose without reset");

	a_gameover_latched: assert property (@(posedge clk) disable iff (!arst_n)
		!$fell(gameover))
		else $error("gameover fell without reset");

	// no tick reaches the player once the game is over
	a_frozen_player: assert property (@(posedge clk) disable iff (!arst_n)
		gameover |=> $stable(player_x) && $stable(player_y))
		else $error("player moved after game over");

endmodule

bind tank_game_top tank_game_checker u_checker (
	.clk           (clk),
	.arst_n        (arst_n),
	.player_x      (player_x),
	.player_y      (player_y),
	.bullet_active (bullet_active),
	.bullet_x      (bullet_x),
	.bullet_y      (bullet_y),
	.hp            (hp),
	.gameover      (gameover)
);

`default_nettype wire

// File: tb_tank_game.sv
/* tank game testbench
   directed tests for reset, movement, bullet flight, kills and collisions */

`timescale 1ns/1ps
`default_nettype none

module tb_tank_game import tank_pkg::*; ();

	localparam int TICK_DIV = 4;
	localparam int PERIOD   = 100;
	// tick budgets of the five tests
	localparam int BUDGET      = 4 + 130 + 80 + 90 + 150;
	localparam int WATCHDOG_NS = BUDGET * TICK_DIV * PERIOD;

	logic   clk = 1'b0;
	logic   arst_n;
	logic   bt_w, bt_a, bt_s, bt_d, bt_st;
	coord_t player_x, player_y;
	coord_t bullet_x, bullet_y;
	dir_t   player_dir;
	logic   bullet_active;
	logic   gameover;
	score_t score;
	hp_t    hp;
	integer seed;

	tank_game_top #(.TICK_DIV(TICK_DIV)) DUT (.*);

	always #(PERIOD / 2) clk = ~clk;

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic give_up(input string reason);
		$display("%0t ns: %s", $time, reason);
		$display("TEST FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		arst_n = 1'b0;
		{bt_w, bt_a, bt_s, bt_d, bt_st} = '0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
	endtask

	// next position change, or none within two move ticks
	task automatic await_move();
		coord_t x0;
		coord_t y0;
		bit     moved;
		x0 = player_x;
		y0 = player_y;
		moved = 1'b0;
		for (int i = 0; i < 2 * TICK_DIV && !moved; i++) begin
			@(negedge clk);
			moved = (player_x != x0) || (player_y != y0);
		end
	endtask

	// hold w or a for n moves, following the cell step by step
	task automatic steer(input dir_t d, input int n);
		int ex;
		int ey;
		ex = player_x;
		ey = player_y;
		@(negedge clk);
		bt_w = (d == DIR_UP);
		bt_a = (d == DIR_LEFT);
		for (int k = 0; k < n; k++) begin
			if (d == DIR_UP)
				ey = (ey > 0) ? ey - 1 : 0;	// clamps at the top edge
			else
				ex = (ex > 0) ? ex - 1 : 0;
			await_move();
			check("player_x", player_x, ex);
			check("player_y", player_y, ey);
		end
		bt_w = 1'b0;
		bt_a = 1'b0;
		check("player_dir", player_dir, d);
	endtask

	task automatic wait_bullet(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (bullet_active !== level && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (bullet_active !== level)
			give_up(level ? "bullet never launched" : "bullet never retired");
	endtask

	task automatic test_reset_state();
		apply_reset();
		check("player_x", player_x, 16);
		check("player_y", player_y, 30);
		check("score", score, 0);
		check("hp", hp, 3);
		check("gameover", gameover, 0);
		check("bullet_active", bullet_active, 0);
	endtask

	task automatic test_movement();
		apply_reset();
		steer(DIR_LEFT, 1 + $unsigned($random(seed)) % 24);
		steer(DIR_UP, 1 + $unsigned($random(seed)) % 34);
	endtask

	task automatic test_bullet_flight();
		int prev_y;
		int n;
		apply_reset();	// faces up, column 16 is free of enemies
		@(negedge clk);
		bt_st = 1'b1;
		wait_bullet(1'b1, 8);
		bt_st = 1'b0;
		check("bullet_x", bullet_x, 16);
		check("bullet_y", bullet_y, 30);
		prev_y = bullet_y;
		n = 0;
		while (bullet_active && n < 64 * TICK_DIV) begin
			bt_st = (n >= 4 && n < 8);	// second press in flight
			@(negedge clk);
			check("bullet_x", bullet_x, 16);
			check("bullet_y not rising", bullet_y <= prev_y, 1);
			prev_y = bullet_y;
			n++;
		end
		if (bullet_active)
			give_up("bullet still flying after 64 ticks");
		else
			check("bullet_y", bullet_y, 0);
		repeat (8) begin
			@(negedge clk);
			check("bullet_active", bullet_active, 0);	// no relaunch
		end
	endtask

	task automatic test_kill();
		int n;
		apply_reset();
		steer(DIR_LEFT, 4);
		steer(DIR_UP, 1);
		// enemy in column 12 has marched about five rows, far from row 30
		@(negedge clk);
		bt_st = 1'b1;
		wait_bullet(1'b1, 8);
		bt_st = 1'b0;
		check("bullet_x", bullet_x, 12);
		n = 0;
		while (score == 0 && n < 64 * TICK_DIV) begin
			@(negedge clk);
			n++;
		end
		if (score == 0)
			give_up("no kill scored within 64 ticks");
		else
			check("score", score, 1);
		check("bullet_active", bullet_active, 0);
		check("hp", hp, 3);
	endtask

	task automatic test_collision();
		int prev_hp;
		int n;
		apply_reset();
		steer(DIR_LEFT, 12);	// column 4, bottom row
		for (int b = 0; b < 3; b++) begin
			prev_hp = 3 - b;	// one point per earlier bump
			n = 0;
			while (hp == prev_hp && n < 40 * TICK_DIV) begin
				@(negedge clk);
				n++;
			end
			if (hp == prev_hp)
				give_up("enemy never ran into the player");
			else
				check("hp", hp, prev_hp - 1);
		end
		check("gameover", gameover, 1);
		@(negedge clk);
		bt_d = 1'b1;
		repeat (4 * TICK_DIV) @(negedge clk);
		bt_d = 1'b0;
		check("player_x", player_x, 4);	// frozen after game over
		check("player_y", player_y, 30);
	endtask

	initial begin
		seed   = 32'hdf1af709;
		arst_n = 1'b0;
		{bt_w, bt_a, bt_s, bt_d, bt_st} = '0;
		test_reset_state();
		test_movement();
		test_bullet_flight();
		test_kill();
		test_collision();
		$display("TEST OK");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		give_up("watchdog expired, a test is stuck");
	end

endmodule

`default_nettype wire

// File: vlog.f
tank_pkg.sv
game_if.sv
game_tick.sv
player_tank.sv
bullet.sv
enemy_tank.sv
game_state.sv
tank_game_top.sv
tank_game_checker.sv
tb_tank_game.sv

// File: Makefile
# Verilator build and run of the tank game testbench

VERILATOR ?= verilator
TOP       ?= tb_tank_game
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
